/* rtl/apb2_defines.svh */
/*
 * APB2 peripheral domain constants
 * Slot map, register offsets, MDIO frame layout and reset values
 */

`ifndef APB2_DEFINES_SVH
`define APB2_DEFINES_SVH

// ====================
// Slot map, paddr[15:12]
// ====================
`define APB2_SLOT_ETH     4'd0
`define APB2_SLOT_ADVTIM  4'd1

// SMA registers
`define SMA_CTRL          12'h000
`define SMA_DATA          12'h004
`define SMA_STAT          12'h008
`define SMA_DIV           12'h00C

// Timer registers
`define TIM_CTRL          12'h000
`define TIM_ARR           12'h004
`define TIM_CCR1          12'h008
`define TIM_DT            12'h00C
`define TIM_STAT          12'h010

// Clause-22 frame
`define MDIO_FRAME_BITS   64
`define MDIO_PRE_BITS     32

`define SMA_DIV_RST       8'd3
`define TIM_ARR_RST       16'hFFFF

`endif

/* rtl/apb2_pkg.sv */
/*
 * APB2 domain types
 * Bus vectors, MDIO fields, timer counts and SMA states
 */

package apb2_pkg;

	// APB
	typedef logic [31:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [3:0]  slot_t;

	// MDIO frame fields
	typedef logic [4:0]  phy_addr_t;
	typedef logic [15:0] mdio_data_t;

	// Count, period, compare and dead time
	typedef logic [15:0] tim_cnt_t;

	// SMA frame sequencer
	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		DONE
	} sma_state_e;

endpackage

/* rtl/apb2_slave_mux.sv */
/*
 * APB2 slave mux
 * Decodes paddr[15:12], steers psel to the selected peripheral and
 * returns its read data; unmapped slots answer with pslverr
 */

`include "apb2_defines.svh"

module apb2_slave_mux
	import apb2_pkg::*;
(
	input  apb_addr_t paddr,
	input  logic      psel,
	input  apb_data_t rdata_eth,
	input  apb_data_t rdata_tim,
	output logic      sel_eth,
	output logic      sel_tim,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr
);

slot_t slot;

assign slot = paddr[15:12];

// ====================
// Select fan-out
// ====================
assign sel_eth = psel && (slot == `APB2_SLOT_ETH);
assign sel_tim = psel && (slot == `APB2_SLOT_ADVTIM);

// No wait states anywhere in the domain
assign pready = 1'b1;

// ====================
// Read response
// ====================
always_comb begin
	prdata  = '0;
	pslverr = 1'b0;
	case (slot)
		`APB2_SLOT_ETH: begin
			prdata = rdata_eth;
		end
		`APB2_SLOT_ADVTIM: begin
			prdata = rdata_tim;
		end
		default: begin
			pslverr = psel;
		end
	endcase
end

endmodule

/* rtl/eth_sma.sv */
/*
 * Ethernet station management controller
 * Runs one clause-22 MDIO read or write frame per SMA_CTRL write,
 * then raises eth_sma_int until software clears it
 */

`include "apb2_defines.svh"

module eth_sma
	import apb2_pkg::*;
(
	input  logic      apb2_root_clk,
	input  logic      rst,
	input  logic      sel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	input  logic      eth_mdio_i,
	output apb_data_t rdata,
	output logic      eth_mdc,
	output logic      eth_mdio_o,
	output logic      eth_mdio_oen,
	output logic      eth_sma_int
);

// Last bit before turnaround
localparam int TA_PREV = `MDIO_FRAME_BITS - 19;
localparam int BIT_W   = $clog2(`MDIO_FRAME_BITS);

logic                        wr_en;
logic                        ctrl_wr;
logic                        busy;
logic                        ctrl_op;
phy_addr_t                   ctrl_phy;
phy_addr_t                   ctrl_reg;
mdio_data_t                  data_q;
logic [7:0]                  div_q;
logic                        int_q;
sma_state_e                  state;
logic [7:0]                  div_cnt;
logic [BIT_W-1:0]            bit_cnt;
logic                        mdc_tick;
logic                        rise_tick;
logic                        fall_tick;
logic [`MDIO_FRAME_BITS-1:0] frame;
logic [`MDIO_FRAME_BITS-1:0] tx_q;
mdio_data_t                  rx_q;

assign wr_en     = sel & penable & pwrite;
assign busy      = (state != IDLE);
assign ctrl_wr   = wr_en && (paddr[11:0] == `SMA_CTRL) && !busy;
assign mdc_tick  = (div_cnt == div_q);
assign rise_tick = (state == SHIFT) && mdc_tick && !eth_mdc;
assign fall_tick = (state == SHIFT) && mdc_tick && eth_mdc;

// Preamble, start, op, phy, reg, turnaround, data
assign frame = {{`MDIO_PRE_BITS{1'b1}}, 2'b01, pwdata[0] ? 2'b10 : 2'b01,
	pwdata[5:1], pwdata[10:6], 2'b10, pwdata[0] ? 16'h0000 : data_q};

// ====================
// Register block
// ====================
always_ff @(posedge apb2_root_clk) begin
	if (rst) begin
		ctrl_op  <= 1'b0;
		ctrl_phy <= '0;
		ctrl_reg <= '0;
		data_q   <= '0;
		div_q    <= `SMA_DIV_RST;
		int_q    <= 1'b0;
	end else begin
		if (ctrl_wr) begin
			ctrl_op  <= pwdata[0];
			ctrl_phy <= pwdata[5:1];
			ctrl_reg <= pwdata[10:6];
		end
		// Divider is frozen during a frame
		if (wr_en && (paddr[11:0] == `SMA_DIV) && !busy)
			div_q <= pwdata[7:0];
		if ((state == DONE) && ctrl_op)
			data_q <= rx_q;
		else if (wr_en && (paddr[11:0] == `SMA_DATA))
			data_q <= pwdata[15:0];
		if (state == DONE)
			int_q <= 1'b1;
		else if (wr_en && (paddr[11:0] == `SMA_STAT) && pwdata[1])
			int_q <= 1'b0;
	end
end

// ====================
// Frame sequencer
// ====================
always_ff @(posedge apb2_root_clk) begin
	if (rst) begin
		state        <= IDLE;
		div_cnt      <= '0;
		bit_cnt      <= '0;
		eth_mdc      <= 1'b0;
		eth_mdio_o   <= 1'b0;
		eth_mdio_oen <= 1'b0;
	end else begin
		case (state)
			IDLE: begin
				if (ctrl_wr) begin
					state        <= SHIFT;
					div_cnt      <= '0;
					bit_cnt      <= '0;
					eth_mdio_o   <= frame[`MDIO_FRAME_BITS-1];
					eth_mdio_oen <= 1'b1;
				end
			end
			SHIFT: begin
				if (mdc_tick) begin
					div_cnt <= '0;
					eth_mdc <= ~eth_mdc;
				end else begin
					div_cnt <= div_cnt + 8'd1;
				end
				// Next bit goes out on the MDC falling edge
				if (fall_tick) begin
					if (bit_cnt == BIT_W'(`MDIO_FRAME_BITS - 1)) begin
						state        <= DONE;
						eth_mdio_o   <= 1'b0;
						eth_mdio_oen <= 1'b0;
					end else begin
						bit_cnt    <= bit_cnt + 1'b1;
						eth_mdio_o <= tx_q[`MDIO_FRAME_BITS-2];
						// PHY owns the line from turnaround on
						if (ctrl_op && (bit_cnt == BIT_W'(TA_PREV)))
							eth_mdio_oen <= 1'b0;
					end
				end
			end
			DONE: begin
				state <= IDLE;
			end
			default: begin
				state <= IDLE;
			end
		endcase
	end
end

// Shift registers, read bits sampled on the MDC rising edge
always_ff @(posedge apb2_root_clk) begin
	if (ctrl_wr)
		tx_q <= frame;
	else if (fall_tick)
		tx_q <= {tx_q[`MDIO_FRAME_BITS-2:0], 1'b0};
	if (rise_tick)
		rx_q <= {rx_q[14:0], eth_mdio_i};
end

// ====================
// Read data
// ====================
always_comb begin
	case (paddr[11:0])
		`SMA_CTRL: rdata = {21'b0, ctrl_reg, ctrl_phy, ctrl_op};
		`SMA_DATA: rdata = {16'b0, data_q};
		`SMA_STAT: rdata = {30'b0, int_q, busy};
		`SMA_DIV:  rdata = {24'b0, div_q};
		default:   rdata = '0;
	endcase
end

assign eth_sma_int = int_q;

endmodule

/* rtl/advtim_pwm.sv */
/*
 * Advanced timer, channel 1 only
 * 16-bit up-counter with one complementary PWM pair, dead time
 * insertion, break input, update and break interrupts
 */

`include "apb2_defines.svh"

module advtim_pwm
	import apb2_pkg::*;
(
	input  logic      apb2_root_clk,
	input  logic      rst,
	input  logic      sel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	input  logic      advtmr0_bk1,
	output apb_data_t rdata,
	output logic      advtmr0_pwm_ch1p,
	output logic      advtmr0_pwm_ch1n,
	output logic      advtmr0_pwm_oen,
	output logic      advtim_gen_int,
	output logic      advtim_brk_int
);

logic     wr_en;
logic     cen;
logic     moe;
tim_cnt_t arr_q;
tim_cnt_t ccr1_q;
tim_cnt_t dt_q;
logic     uif;
logic     bif;
tim_cnt_t cnt;
tim_cnt_t dtp;
tim_cnt_t dtn;
logic     wrap;
logic     oc1ref;

assign wr_en  = sel & penable & pwrite;
assign wrap   = cen && (cnt >= arr_q);
assign oc1ref = (cnt < ccr1_q);

// ====================
// Register block
// ====================
always_ff @(posedge apb2_root_clk) begin
	if (rst) begin
		cen    <= 1'b0;
		moe    <= 1'b0;
		arr_q  <= `TIM_ARR_RST;
		ccr1_q <= '0;
		dt_q   <= '0;
		uif    <= 1'b0;
		bif    <= 1'b0;
	end else begin
		if (wr_en && (paddr[11:0] == `TIM_CTRL)) begin
			cen <= pwdata[0];
			moe <= pwdata[1];
		end
		// Break overrides any MOE write
		if (advtmr0_bk1)
			moe <= 1'b0;
		if (wr_en && (paddr[11:0] == `TIM_ARR))
			arr_q <= pwdata[15:0];
		if (wr_en && (paddr[11:0] == `TIM_CCR1))
			ccr1_q <= pwdata[15:0];
		if (wr_en && (paddr[11:0] == `TIM_DT))
			dt_q <= pwdata[15:0];
		if (wrap)
			uif <= 1'b1;
		else if (wr_en && (paddr[11:0] == `TIM_STAT) && pwdata[0])
			uif <= 1'b0;
		if (advtmr0_bk1)
			bif <= 1'b1;
		else if (wr_en && (paddr[11:0] == `TIM_STAT) && pwdata[1])
			bif <= 1'b0;
	end
end

// ====================
// Counter and dead time
// ====================
always_ff @(posedge apb2_root_clk) begin
	if (rst) begin
		cnt <= '0;
		dtp <= '0;
		dtn <= '0;
	end else begin
		if (cen)
			cnt <= wrap ? '0 : cnt + 16'd1;
		// Each counter delays the rising edge of its own output
		if (!oc1ref)
			dtp <= '0;
		else if (dtp < dt_q)
			dtp <= dtp + 16'd1;
		if (oc1ref)
			dtn <= '0;
		else if (dtn < dt_q)
			dtn <= dtn + 16'd1;
	end
end

assign advtmr0_pwm_ch1p = moe && oc1ref && (dtp >= dt_q);
assign advtmr0_pwm_ch1n = moe && !oc1ref && (dtn >= dt_q);
assign advtmr0_pwm_oen  = moe;

assign advtim_gen_int = uif;
assign advtim_brk_int = bif;

// ====================
// Read data
// ====================
always_comb begin
	case (paddr[11:0])
		`TIM_CTRL: rdata = {30'b0, moe, cen};
		`TIM_ARR:  rdata = {16'b0, arr_q};
		`TIM_CCR1: rdata = {16'b0, ccr1_q};
		`TIM_DT:   rdata = {16'b0, dt_q};
		`TIM_STAT: rdata = {30'b0, bif, uif};
		default:   rdata = '0;
	endcase
end

endmodule

/* rtl/apb2_top.sv */
/*
 * APB2 peripheral domain top
 * Slave mux with the SMA controller on slot 0 and the
 * advanced timer on slot 1, all on apb2_root_clk
 */

module apb2_top
	import apb2_pkg::*;
(
	input  logic      apb2_root_clk,
	input  logic      rst,

	// APB
	input  apb_addr_t paddr,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,

	// Pins
	output logic      eth_mdc,
	output logic      eth_mdio_o,
	input  logic      eth_mdio_i,
	output logic      eth_mdio_oen,
	output logic      advtmr0_pwm_ch1p,
	output logic      advtmr0_pwm_ch1n,
	output logic      advtmr0_pwm_oen,
	input  logic      advtmr0_bk1,

	// Interrupts
	output logic      eth_sma_int,
	output logic      advtim_gen_int,
	output logic      advtim_brk_int
);

logic      sel_eth;
logic      sel_tim;
apb_data_t rdata_eth;
apb_data_t rdata_tim;

// ====================
// Slave mux
// ====================
apb2_slave_mux u_apb2_slave_mux (
	.paddr     (paddr),
	.psel      (psel),
	.rdata_eth (rdata_eth),
	.rdata_tim (rdata_tim),
	.sel_eth   (sel_eth),
	.sel_tim   (sel_tim),
	.prdata    (prdata),
	.pready    (pready),
	.pslverr   (pslverr)
);

// Slot 0, 0x0000 to 0x0FFF
eth_sma u_eth_sma (
	.apb2_root_clk (apb2_root_clk),
	.rst           (rst),
	.sel           (sel_eth),
	.penable       (penable),
	.pwrite        (pwrite),
	.paddr         (paddr),
	.pwdata        (pwdata),
	.eth_mdio_i    (eth_mdio_i),
	.rdata         (rdata_eth),
	.eth_mdc       (eth_mdc),
	.eth_mdio_o    (eth_mdio_o),
	.eth_mdio_oen  (eth_mdio_oen),
	.eth_sma_int   (eth_sma_int)
);

// Slot 1, 0x1000 to 0x1FFF
advtim_pwm u_advtim_pwm (
	.apb2_root_clk    (apb2_root_clk),
	.rst              (rst),
	.sel              (sel_tim),
	.penable          (penable),
	.pwrite           (pwrite),
	.paddr            (paddr),
	.pwdata           (pwdata),
	.advtmr0_bk1      (advtmr0_bk1),
	.rdata            (rdata_tim),
	.advtmr0_pwm_ch1p (advtmr0_pwm_ch1p),
	.advtmr0_pwm_ch1n (advtmr0_pwm_ch1n),
	.advtmr0_pwm_oen  (advtmr0_pwm_oen),
	.advtim_gen_int   (advtim_gen_int),
	.advtim_brk_int   (advtim_brk_int)
);

endmodule

/* dv/apb2_chk.sv */
/*
 * APB2 domain checker
 * Bus, PWM pair, break and MDIO direction rules
 */

module apb2_chk (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic pready,
	input logic ch1p,
	input logic ch1n,
	input logic pwm_oen,
	input logic bk1,
	input logic busy,
	input logic mdio_oen
);

timeunit 1ns;
timeprecision 1ps;

a_pready: assert property (@(posedge clk) disable iff (rst) psel |-> pready)
	else $error("pready low during a selected access");

a_pair: assert property (@(posedge clk) disable iff (rst) !(ch1p && ch1n))
	else $error("ch1p and ch1n high together");

// Break takes the outputs down one cycle later
a_break: assert property (@(posedge clk) disable iff (rst)
	bk1 |=> (!ch1p && !ch1n && !pwm_oen))
	else $error("PWM outputs still active after break");

a_mdio_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> !mdio_oen)
	else $error("MDIO driven while SMA is idle");

endmodule

bind apb2_top apb2_chk u_apb2_chk (
	.clk      (apb2_root_clk),
	.rst      (rst),
	.psel     (psel),
	.pready   (pready),
	.ch1p     (advtmr0_pwm_ch1p),
	.ch1n     (advtmr0_pwm_ch1n),
	.pwm_oen  (advtmr0_pwm_oen),
	.bk1      (advtmr0_bk1),
	.busy     (u_eth_sma.busy),
	.mdio_oen (eth_mdio_oen)
);

/* dv/apb2_tb.sv */
/*
 * APB2 domain testbench
 * APB tasks, MDIO PHY model and PWM measurement
 */

`include "apb2_defines.svh"

module apb2_tb
	import apb2_pkg::*;
;

timeunit 1ns;
timeprecision 1ps;

logic clk, rst, psel, penable, pwrite, pready, pslverr;
apb_addr_t paddr;
apb_data_t pwdata, prdata;
logic eth_mdc, eth_mdio_o, eth_mdio_i, eth_mdio_oen, eth_sma_int;
logic ch1p, ch1n, pwm_oen, bk1, gen_int, brk_int;
logic [63:0] rec_bits;
logic [63:0] rec_oen;
logic mdc_prev;
int rise_cnt, cycles;
mdio_data_t phy_word;

apb2_top u_apb2_top (
	.apb2_root_clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
	.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
	.pslverr(pslverr), .eth_mdc(eth_mdc), .eth_mdio_o(eth_mdio_o),
	.eth_mdio_i(eth_mdio_i), .eth_mdio_oen(eth_mdio_oen),
	.advtmr0_pwm_ch1p(ch1p), .advtmr0_pwm_ch1n(ch1n), .advtmr0_pwm_oen(pwm_oen),
	.advtmr0_bk1(bk1), .eth_sma_int(eth_sma_int), .advtim_gen_int(gen_int),
	.advtim_brk_int(brk_int)
);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

// Three frames at div 3 plus PWM windows
always @(posedge clk) begin
	cycles++;
	if (cycles >= 20000) begin
		$display("run timed out after %0d cycles", cycles);
		$display("test failed");
		$fatal(1);
	end
end

// ====================
// PHY model
// ====================
always begin
	@(posedge clk);
	#1;
	if (eth_mdc && !mdc_prev) begin
		rec_bits = {rec_bits[62:0], eth_mdio_o};
		rec_oen = {rec_oen[62:0], eth_mdio_oen};
		rise_cnt++;
	end
	mdc_prev = eth_mdc;
	eth_mdio_i = (rise_cnt >= 48 && rise_cnt < 64) ? phy_word[63-rise_cnt] : 1'b0;
end

function automatic logic [63:0] sma_frame(logic op, phy_addr_t phy, phy_addr_t rg,
	mdio_data_t d);
	sma_frame = {32'hFFFF_FFFF, 2'b01, op ? 2'b10 : 2'b01, phy, rg, 2'b10,
		op ? 16'h0000 : d};
endfunction

// High cycles per period of ch1p (neg low) or ch1n (neg high)
function automatic tim_cnt_t pwm_high(int arr, int ccr, int dt, logic neg);
	int on_len;
	on_len = neg ? (arr + 1 - ccr) : ccr;
	pwm_high = (on_len > dt) ? tim_cnt_t'(on_len - dt) : '0;
endfunction

// Bus address from slot number and register offset
function automatic apb_addr_t eth_addr(logic [11:0] off);
	eth_addr = {16'h0, `APB2_SLOT_ETH, off};
endfunction

function automatic apb_addr_t tim_addr(logic [11:0] off);
	tim_addr = {16'h0, `APB2_SLOT_ADVTIM, off};
endfunction

task automatic report_error(string name, string exp_s, string act_s);
	$display("** Error %s: expected %s, actual %s", name, exp_s, act_s);
	$display("test failed");
	$fatal(1);
endtask

task automatic check_data(string name, apb_data_t exp, apb_data_t act);
	if (exp !== act)
		report_error(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_mdio(string name, mdio_data_t exp, mdio_data_t act);
	if (exp !== act)
		report_error(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_cnt(string name, tim_cnt_t exp, tim_cnt_t act);
	if (exp !== act)
		report_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_bit(string name, logic exp, logic act);
	if (exp !== act)
		report_error(name, $sformatf("%b", exp), $sformatf("%b", act));
endtask

// ====================
// APB tasks
// ====================
task automatic apb_write(apb_addr_t addr, apb_data_t data);
	@(posedge clk);
	#1;
	paddr = addr;
	pwdata = data;
	pwrite = 1'b1;
	psel = 1'b1;
	@(posedge clk);
	#1;
	penable = 1'b1;
	@(posedge clk);
	#1;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apb_read(apb_addr_t addr, output apb_data_t data, output logic err);
	@(posedge clk);
	#1;
	paddr = addr;
	pwrite = 1'b0;
	psel = 1'b1;
	@(posedge clk);
	#1;
	penable = 1'b1;
	#3;
	data = prdata;
	err = pslverr;
	check_bit("pready", 1'b1, pready);
	@(posedge clk);
	#1;
	psel = 1'b0;
	penable = 1'b0;
endtask

task automatic wait_idle();
	apb_data_t st;
	logic err;
	st = 32'h1;
	while (st[0])
		apb_read(eth_addr(`SMA_STAT), st, err);
endtask

task automatic count_high(int n, output tim_cnt_t hp, output tim_cnt_t hn);
	hp = '0;
	hn = '0;
	repeat (n) begin
		@(posedge clk);
		#1;
		hp += tim_cnt_t'(ch1p);
		hn += tim_cnt_t'(ch1n);
	end
endtask

initial begin
	apb_data_t rd, ctrl1, div_w;
	logic err;
	logic [63:0] exp_f;
	phy_addr_t phy, rg;
	mdio_data_t wd;
	int arr, ccr, dt;
	tim_cnt_t hp, hn;

	void'($urandom(32'h1fd7adda));
	{psel, penable, pwrite, bk1, eth_mdio_i, mdc_prev} = '0;
	paddr = '0;
	pwdata = '0;
	phy_word = '0;
	rec_bits = '0;
	rec_oen = '0;
	rise_cnt = 0;
	cycles = 0;
	rst = 1'b1;
	repeat (16) @(posedge clk);
	#1;
	rst = 1'b0;

	// Reset and decode
	check_bit("reset pins", 1'b0, eth_mdc | eth_mdio_o | eth_mdio_oen | ch1p | ch1n);
	check_bit("reset ints", 1'b0, pwm_oen | eth_sma_int | gen_int | brk_int);
	apb_read(eth_addr(`SMA_DIV), rd, err);
	check_data("div reset", 32'd3, rd);
	div_w = {24'h0, 8'd64 + 8'($urandom % 64)};
	apb_write(eth_addr(`SMA_DIV), div_w);
	apb_read(eth_addr(`SMA_DIV), rd, err);
	check_data("div readback", div_w, rd);
	apb_write(eth_addr(`SMA_DIV), 32'd3);
	wd = mdio_data_t'($urandom);
	apb_write(tim_addr(`TIM_ARR), {16'h0, wd});
	apb_read(tim_addr(`TIM_ARR), rd, err);
	check_data("arr readback", {16'h0, wd}, rd);
	wd = mdio_data_t'($urandom);
	apb_write(tim_addr(`TIM_CCR1), {16'h0, wd});
	apb_read(tim_addr(`TIM_CCR1), rd, err);
	check_data("ccr1 readback", {16'h0, wd}, rd);
	wd = mdio_data_t'($urandom);
	apb_write(tim_addr(`TIM_DT), {16'h0, wd});
	apb_read(tim_addr(`TIM_DT), rd, err);
	check_data("dt readback", {16'h0, wd}, rd);
	apb_read(32'h5000, rd, err);
	check_bit("slot 5 pslverr", 1'b1, err);
	check_data("slot 5 data", 32'h0, rd);

	// MDIO write frame
	phy = phy_addr_t'($urandom);
	rg = phy_addr_t'($urandom);
	wd = mdio_data_t'($urandom);
	apb_write(eth_addr(`SMA_DATA), {16'h0, wd});
	rise_cnt = 0;
	apb_write(eth_addr(`SMA_CTRL), {21'h0, rg, phy, 1'b0});
	wait_idle();
	exp_f = sma_frame(1'b0, phy, rg, wd);
	check_mdio("write frame 3", exp_f[63:48], rec_bits[63:48]);
	check_mdio("write frame 2", exp_f[47:32], rec_bits[47:32]);
	check_mdio("write frame 1", exp_f[31:16], rec_bits[31:16]);
	check_mdio("write frame 0", exp_f[15:0], rec_bits[15:0]);
	check_bit("sma int set", 1'b1, eth_sma_int);
	apb_write(eth_addr(`SMA_STAT), 32'h2);
	check_bit("sma int clear", 1'b0, eth_sma_int);

	// MDIO read frame and header bits
	phy = phy_addr_t'($urandom);
	rg = phy_addr_t'($urandom);
	phy_word = mdio_data_t'($urandom);
	rise_cnt = 0;
	apb_write(eth_addr(`SMA_CTRL), {21'h0, rg, phy, 1'b1});
	wait_idle();
	apb_read(eth_addr(`SMA_DATA), rd, err);
	check_mdio("read data", phy_word, rd[15:0]);
	exp_f = sma_frame(1'b1, phy, rg, 16'h0);
	check_mdio("read header 3", exp_f[63:48], rec_bits[63:48]);
	check_mdio("read header 2", exp_f[47:32], rec_bits[47:32]);
	check_mdio("read header 1", {2'b0, exp_f[31:18]}, {2'b0, rec_bits[31:18]});
	// PHY owns the line from turnaround to the end of the frame
	check_bit("read oen header", 1'b1, &rec_oen[63:18]);
	check_bit("read oen turnaround", 1'b0, rec_oen[17] | rec_oen[16]);
	check_mdio("read oen data", 16'h0, rec_oen[15:0]);
	apb_write(eth_addr(`SMA_STAT), 32'h2);

	// Busy rule
	phy = phy_addr_t'($urandom);
	rg = phy_addr_t'($urandom);
	ctrl1 = {21'h0, rg, phy, 1'b0};
	rise_cnt = 0;
	apb_write(eth_addr(`SMA_CTRL), ctrl1);
	apb_write(eth_addr(`SMA_CTRL), ctrl1 ^ 32'h7FE);
	wait_idle();
	check_cnt("busy frame length", 16'd64, tim_cnt_t'(rise_cnt));
	apb_read(eth_addr(`SMA_CTRL), rd, err);
	check_data("busy ctrl kept", ctrl1, rd);
	apb_write(eth_addr(`SMA_STAT), 32'h2);

	// PWM duty
	arr = 20 + int'($urandom % 60);
	ccr = 3 + int'($urandom % (arr - 6));
	dt = 1 + int'($urandom % (ccr - 1));
	apb_write(tim_addr(`TIM_ARR), arr);
	apb_write(tim_addr(`TIM_CCR1), ccr);
	apb_write(tim_addr(`TIM_DT), dt);
	apb_write(tim_addr(`TIM_CTRL), 32'h3);
	repeat (2 * (arr + 1)) @(posedge clk);
	count_high(arr + 1, hp, hn);
	check_cnt("ch1p high", pwm_high(arr, ccr, dt, 1'b0), hp);
	check_cnt("ch1n high", pwm_high(arr, ccr, dt, 1'b1), hn);
	check_bit("update flag", 1'b1, gen_int);
	apb_write(tim_addr(`TIM_CTRL), 32'h2);
	apb_write(tim_addr(`TIM_STAT), 32'h1);
	check_bit("update clear", 1'b0, gen_int);
	apb_write(tim_addr(`TIM_CTRL), 32'h3);

	// Break
	repeat (arr) @(posedge clk);
	#1;
	bk1 = 1'b1;
	@(posedge clk);
	@(posedge clk);
	#1;
	check_bit("break outputs", 1'b0, ch1p | ch1n | pwm_oen);
	bk1 = 1'b0;
	check_bit("break int", 1'b1, brk_int);
	apb_read(tim_addr(`TIM_STAT), rd, err);
	check_bit("break flag", 1'b1, rd[1]);
	apb_write(tim_addr(`TIM_STAT), 32'h2);
	check_bit("break clear", 1'b0, brk_int);
	apb_write(tim_addr(`TIM_CTRL), 32'h3);
	repeat (arr + 1) @(posedge clk);
	count_high(arr + 1, hp, hn);
	check_cnt("ch1p after break", pwm_high(arr, ccr, dt, 1'b0), hp);
	check_cnt("ch1n after break", pwm_high(arr, ccr, dt, 1'b1), hn);

	$display("test passed");
	$finish;
end

endmodule

/* all.f */
+incdir+rtl
rtl/apb2_pkg.sv
rtl/apb2_slave_mux.sv
rtl/eth_sma.sv
rtl/advtim_pwm.sv
rtl/apb2_top.sv
dv/apb2_chk.sv
dv/apb2_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the APB2 domain testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module apb2_tb -o Vapb2_tb

# The testbench stops with a nonzero status on failure; the log decides
./obj_dir/Vapb2_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
if ! grep -q "test passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
